// ==== ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    localparam int OPCODE_W = 6;
    localparam int FUNCT_W  = 6;
    localparam int STEP_W   = 2;

    // opcodes
    localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'h00;
    localparam logic [OPCODE_W-1:0] OP_SLTI  = 6'h0a;

    // R-type funct codes
    localparam logic [FUNCT_W-1:0] FN_ADD  = 6'h20;
    localparam logic [FUNCT_W-1:0] FN_SLL  = 6'h00;
    localparam logic [FUNCT_W-1:0] FN_SLLV = 6'h04;
    localparam logic [FUNCT_W-1:0] FN_SLT  = 6'h2a;
    localparam logic [FUNCT_W-1:0] FN_SRA  = 6'h03;
    localparam logic [FUNCT_W-1:0] FN_SRAV = 6'h07;

    // alu operations
    localparam logic [2:0] ALU_NONE = 3'd0;
    localparam logic [2:0] ALU_ADD  = 3'd1;
    localparam logic [2:0] ALU_CMP  = 3'd7;

    // alu operand selects
    localparam logic [2:0] SRCA_PC     = 3'd0;
    localparam logic [2:0] SRCA_A      = 3'd2;
    localparam logic [2:0] SRCA_A_CMP  = 3'd4;
    localparam logic [2:0] SRCB_B      = 3'd0;
    localparam logic [2:0] SRCB_FOUR   = 3'd1;
    localparam logic [2:0] SRCB_OFFSET = 3'd3;
    localparam logic [2:0] SRCB_IMM    = 3'd4;

    // register file write side
    localparam logic [2:0] DST_RT    = 3'd0;
    localparam logic [2:0] DST_RD    = 3'd2;
    localparam logic [2:0] DST_SP    = 3'd4;
    localparam logic [2:0] M2R_NONE  = 3'd0;
    localparam logic [2:0] M2R_SHIFT = 3'd2;
    localparam logic [2:0] M2R_LT    = 3'd5;
    localparam logic [2:0] M2R_ALU   = 3'd6;

    // shift register
    localparam logic [1:0] SRIN_NONE   = 2'd0;
    localparam logic [1:0] SRIN_A      = 2'd1;
    localparam logic [2:0] SR_IDLE     = 3'd0;
    localparam logic [2:0] SR_LOAD     = 3'd1;
    localparam logic [2:0] SR_SHL      = 3'd2;
    localparam logic [2:0] SR_SRA      = 3'd4;
    localparam logic [1:0] SRNUM_RS    = 2'd0;
    localparam logic [1:0] SRNUM_SHAMT = 2'd1;

    typedef logic [STEP_W-1:0] stepT;

    // last step of each sequence length
    localparam stepT LAST_FETCH = 2'd2;
    localparam stepT LAST_SHORT = 2'd1;
    localparam stepT LAST_SHIFT = 2'd2;

    // fetch is zero so a fresh 2-state register starts in fetch
    typedef enum bit [3:0] {
        PH_FETCH   = 4'd0,
        PH_ADD     = 4'd1,
        PH_SLT     = 4'd2,
        PH_SLTI    = 4'd3,
        PH_SLL     = 4'd4,
        PH_SLLV    = 4'd5,
        PH_SRA     = 4'd6,
        PH_SRAV    = 4'd7,
        PH_RESET   = 4'd8,
        PH_SP_INIT = 4'd9
    } phaseT;

    typedef struct packed {
        phaseT phase;
        stepT  step;
    } seqPosT;

    typedef struct packed {
        logic       pcWrite;
        logic       memRW;
        logic       irWrite;
        logic       regWrite;
        logic [2:0] aluOp;
        logic [2:0] iOrD;
        logic [2:0] aluSrcA;
        logic [2:0] aluSrcB;
        logic [2:0] regDst;
        logic [2:0] memToReg;
        logic [2:0] pcSource;
        logic [1:0] srInputSel;
        logic [2:0] srControl;
        logic [1:0] srNumSel;
        logic       rstOut;
    } ctrlWordT;

    // every datapath control at rest
    localparam ctrlWordT CTRL_IDLE = '{
        pcWrite:    1'b0,
        memRW:      1'b0,
        irWrite:    1'b0,
        regWrite:   1'b0,
        aluOp:      ALU_NONE,
        iOrD:       3'd0,
        aluSrcA:    SRCA_PC,
        aluSrcB:    SRCB_B,
        regDst:     DST_RT,
        memToReg:   M2R_NONE,
        pcSource:   3'd0,
        srInputSel: SRIN_NONE,
        srControl:  SR_IDLE,
        srNumSel:   SRNUM_RS,
        rstOut:     1'b0
    };

endpackage

`default_nettype wire

// ==== instrDecoder.sv ====
`default_nettype none

module instrDecoder import ctrlPkg::*; (
    input  wire logic [OPCODE_W-1:0] opcode,
    input  wire logic [FUNCT_W-1:0]  funct,
    output phaseT                    dispatchPhase
);

    always_comb begin
        dispatchPhase = PH_FETCH;
        case (opcode)
            OP_RTYPE: begin
                case (funct)
                    FN_ADD:  dispatchPhase = PH_ADD;
                    FN_SLT:  dispatchPhase = PH_SLT;
                    FN_SLL:  dispatchPhase = PH_SLL;
                    FN_SLLV: dispatchPhase = PH_SLLV;
                    FN_SRA:  dispatchPhase = PH_SRA;
                    FN_SRAV: dispatchPhase = PH_SRAV;
                    // unsupported funct just refetches
                    default: dispatchPhase = PH_FETCH;
                endcase
            end
            OP_SLTI: begin
                dispatchPhase = PH_SLTI;
            end
            default: begin
                dispatchPhase = PH_FETCH;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== stepSequencer.sv ====
`default_nettype none

module stepSequencer import ctrlPkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  phaseT     dispatchPhase,
    output seqPosT    issuePos
);

    phaseT phase;
    stepT  step;
    phaseT nextPhase;
    stepT  nextStep;
    stepT  lastStep;

    always_comb begin
        case (phase)
            PH_FETCH: lastStep = LAST_FETCH;
            PH_ADD,
            PH_SLT,
            PH_SLTI:  lastStep = LAST_SHORT;
            PH_SLL,
            PH_SLLV,
            PH_SRA,
            PH_SRAV:  lastStep = LAST_SHIFT;
            default:  lastStep = '0;
        endcase
    end

    // row issued at the coming edge
    always_comb begin
        if (rst) begin
            issuePos.phase = (phase == PH_RESET) ? PH_SP_INIT : PH_RESET;
            issuePos.step  = '0;
        end else begin
            issuePos.phase = phase;
            issuePos.step  = step;
        end
    end

    always_comb begin
        nextPhase = phase;
        nextStep  = step + stepT'(1);
        if (rst) begin
            // clearing cycle, then sp-init which lands in fetch
            nextPhase = (phase == PH_RESET) ? PH_FETCH : PH_RESET;
            nextStep  = '0;
        end else if (step == lastStep) begin
            nextPhase = (phase == PH_FETCH) ? dispatchPhase : PH_FETCH;
            nextStep  = '0;
        end
    end

    always_ff @(posedge clk) begin
        phase <= nextPhase;
        step  <= nextStep;
    end

endmodule

`default_nettype wire

// ==== controlWordGen.sv ====
`default_nettype none

module controlWordGen import ctrlPkg::*; (
    input  wire logic clk,
    input  seqPosT    issuePos,
    output ctrlWordT  ctrl
);

    ctrlWordT word;
    logic     leftShift;
    logic     shamtShift;

    // shift flavour from the phase
    assign leftShift  = (issuePos.phase == PH_SLL) || (issuePos.phase == PH_SLLV);
    assign shamtShift = (issuePos.phase == PH_SLL) || (issuePos.phase == PH_SRA);

    always_comb begin
        word = CTRL_IDLE;
        case (issuePos.phase)
            PH_FETCH: begin
                // step 0 stays idle while memory is read
                if (issuePos.step == 2'd1) begin
                    word.pcWrite = 1'b1;
                    word.irWrite = 1'b1;
                    word.aluOp   = ALU_ADD;
                    word.aluSrcA = SRCA_PC;
                    word.aluSrcB = SRCB_FOUR;
                end else if (issuePos.step == 2'd2) begin
                    word.pcWrite = 1'b1;
                    word.irWrite = 1'b1;
                    word.aluOp   = ALU_ADD;
                    word.aluSrcB = SRCB_OFFSET;
                end
            end
            PH_ADD: begin
                word.aluOp   = ALU_ADD;
                word.aluSrcA = SRCA_A;
                if (issuePos.step == 2'd1) begin
                    word.regWrite = 1'b1;
                    word.regDst   = DST_RD;
                    word.memToReg = M2R_ALU;
                end
            end
            PH_SLT,
            PH_SLTI: begin
                if (issuePos.step == 2'd0) begin
                    word.aluOp   = ALU_CMP;
                    word.aluSrcA = SRCA_A_CMP;
                    if (issuePos.phase == PH_SLTI) begin
                        word.aluSrcB = SRCB_IMM;
                    end
                end else begin
                    word.regWrite = 1'b1;
                    word.memToReg = M2R_LT;
                end
            end
            PH_SLL,
            PH_SLLV,
            PH_SRA,
            PH_SRAV: begin
                case (issuePos.step)
                    2'd0: begin
                        word.srInputSel = SRIN_A;
                        word.srControl  = SR_LOAD;
                    end
                    2'd1: begin
                        word.srControl = leftShift ? SR_SHL : SR_SRA;
                        word.srNumSel  = shamtShift ? SRNUM_SHAMT : SRNUM_RS;
                    end
                    default: begin
                        // shifted value written back
                        word.regDst   = DST_SP;
                        word.memToReg = M2R_SHIFT;
                    end
                endcase
            end
            PH_RESET: begin
                word.rstOut = 1'b1;
            end
            PH_SP_INIT: begin
                word.regWrite = 1'b1;
                word.regDst   = DST_SP;
                word.rstOut   = 1'b1;
            end
            default: begin
                word = CTRL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        ctrl <= word;
    end

endmodule

`default_nettype wire

// ==== controlUnit.sv ====
`default_nettype none

module controlUnit import ctrlPkg::*; (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic [OPCODE_W-1:0] opcode,
    input  wire logic [FUNCT_W-1:0]  funct,
    output ctrlWordT                 ctrl
);

    phaseT  dispatchPhase;
    seqPosT issuePos;

    instrDecoder decoder (
        .opcode        (opcode),
        .funct         (funct),
        .dispatchPhase (dispatchPhase)
    );

    // phase and step, plus the two-stage reset
    stepSequencer sequencer (
        .clk           (clk),
        .rst           (rst),
        .dispatchPhase (dispatchPhase),
        .issuePos      (issuePos)
    );

    controlWordGen wordGen (
        .clk      (clk),
        .issuePos (issuePos),
        .ctrl     (ctrl)
    );

endmodule

`default_nettype wire

// ==== controlUnitTb.sv ====
`default_nettype none

module controlUnitTb import ctrlPkg::*; ();

    logic                clk;
    logic                rst;
    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT_W-1:0]  funct;
    ctrlWordT            ctrl;

    int testErrors;
    int testsPassed;
    int testsFailed;
    int order [9];

    controlUnit DUT (
        .clk    (clk),
        .rst    (rst),
        .opcode (opcode),
        .funct  (funct),
        .ctrl   (ctrl)
    );

    always #50 clk = ~clk;

    // 12 tests at up to 60 cycles each, plus the reset cycles
    initial begin
        #((12 * 60 + 4) * 100);
        $display("ERROR: simulation timed out before all tests finished");
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic ctrlWordT expectedWord(input phaseT ph, input stepT st);
        ctrlWordT w;
        w = '0;
        case (ph)
            PH_FETCH: begin
                // step 0 is the idle word
                if (st != 2'd0) begin
                    w.pcWrite = 1'b1;
                    w.irWrite = 1'b1;
                    w.aluOp   = ALU_ADD;
                    w.aluSrcB = (st == 2'd1) ? SRCB_FOUR : SRCB_OFFSET;
                end
            end
            PH_ADD: begin
                w.aluOp   = ALU_ADD;
                w.aluSrcA = SRCA_A;
                if (st == 2'd1) begin
                    w.regWrite = 1'b1;
                    w.regDst   = DST_RD;
                    w.memToReg = M2R_ALU;
                end
            end
            PH_SLT, PH_SLTI: begin
                if (st == 2'd0) begin
                    w.aluOp   = ALU_CMP;
                    w.aluSrcA = SRCA_A_CMP;
                    w.aluSrcB = (ph == PH_SLTI) ? SRCB_IMM : SRCB_B;
                end else begin
                    w.regWrite = 1'b1;
                    w.memToReg = M2R_LT;
                end
            end
            PH_SLL, PH_SLLV, PH_SRA, PH_SRAV: begin
                if (st == 2'd0) begin
                    w.srInputSel = SRIN_A;
                    w.srControl  = SR_LOAD;
                end else if (st == 2'd1) begin
                    case (ph)
                        PH_SLL:  w.srNumSel = SRNUM_SHAMT;
                        PH_SRA:  w.srNumSel = SRNUM_SHAMT;
                        default: w.srNumSel = SRNUM_RS;
                    endcase
                    if (ph == PH_SRA || ph == PH_SRAV) begin
                        w.srControl = SR_SRA;
                    end else begin
                        w.srControl = SR_SHL;
                    end
                end else begin
                    w.regDst   = DST_SP;
                    w.memToReg = M2R_SHIFT;
                end
            end
            PH_RESET: begin
                w.rstOut = 1'b1;
            end
            PH_SP_INIT: begin
                w.regWrite = 1'b1;
                w.regDst   = DST_SP;
                w.rstOut   = 1'b1;
            end
            default: begin
                w = '0;
            end
        endcase
        return w;
    endfunction

    // number of execute words after fetch
    function automatic int execSteps(input phaseT ph);
        case (ph)
            PH_ADD, PH_SLT, PH_SLTI:          return 2;
            PH_SLL, PH_SLLV, PH_SRA, PH_SRAV: return 3;
            default:                          return 0;
        endcase
    endfunction

    task automatic showWord(input string label, input ctrlWordT w);
        $display("    %s pc=%b mem=%b ir=%b reg=%b alu=%0d iOrD=%0d srcA=%0d srcB=%0d",
            label, w.pcWrite, w.memRW, w.irWrite, w.regWrite, w.aluOp, w.iOrD,
            w.aluSrcA, w.aluSrcB);
        $display("    %s dst=%0d m2r=%0d pcSrc=%0d srIn=%0d srCtl=%0d srNum=%0d rstOut=%b",
            label, w.regDst, w.memToReg, w.pcSource, w.srInputSel, w.srControl,
            w.srNumSel, w.rstOut);
    endtask

    // one rising edge, then look at ctrl while it is stable
    task automatic checkNext(input ctrlWordT exp, input string what);
        @(posedge clk);
        @(negedge clk);
        if (ctrl !== exp) begin
            $display("FAIL t=%0t %s: ctrl %h, expected %h", $time, what, ctrl, exp);
            showWord("got     ", ctrl);
            showWord("expected", exp);
            testErrors = testErrors + 1;
        end
    endtask

    task automatic finishTest(input string name);
        if (testErrors == 0) begin
            $display("test %s: ok", name);
            testsPassed = testsPassed + 1;
        end else begin
            $display("test %s: failed with %0d errors", name, testErrors);
            testsFailed = testsFailed + 1;
        end
        testErrors = 0;
    endtask

    task automatic resetTest();
        checkNext(expectedWord(PH_RESET, 2'd0), "reset clear 1");
        checkNext(expectedWord(PH_SP_INIT, 2'd0), "reset sp init 1");
        checkNext(expectedWord(PH_RESET, 2'd0), "reset clear 2");
        checkNext(expectedWord(PH_SP_INIT, 2'd0), "reset sp init 2");
        rst = 1'b0;
        checkNext(expectedWord(PH_FETCH, 2'd0), "reset then fetch 0");
        finishTest("reset");
    endtask

    task automatic fetchTest();
        checkNext(expectedWord(PH_FETCH, 2'd1), "fetch 1");
        checkNext(expectedWord(PH_FETCH, 2'd2), "fetch 2");
        checkNext(expectedWord(PH_FETCH, 2'd0), "fetch back to 0");
        finishTest("fetch");
    endtask

    // starts right after a fetch 0 word, ends on the next one
    task automatic runInstr(input logic [OPCODE_W-1:0] op, input logic [FUNCT_W-1:0] fn,
                            input phaseT ph, input string name);
        int n;
        int s;
        n = execSteps(ph);
        checkNext(expectedWord(PH_FETCH, 2'd1), {name, " fetch 1"});
        opcode = op;
        funct  = fn;
        checkNext(expectedWord(PH_FETCH, 2'd2), {name, " fetch 2"});
        for (s = 0; s < n; s = s + 1) begin
            checkNext(expectedWord(ph, stepT'(s)), {name, " execute"});
        end
        checkNext(expectedWord(PH_FETCH, 2'd0), {name, " next fetch 0"});
        finishTest(name);
    endtask

    task automatic runTestById(input int id);
        case (id)
            0: runInstr(OP_RTYPE, FN_ADD, PH_ADD, "add");
            1: runInstr(OP_RTYPE, FN_SLT, PH_SLT, "slt");
            2: runInstr(OP_SLTI, 6'h15, PH_SLTI, "slti");
            3: runInstr(OP_RTYPE, FN_SLL, PH_SLL, "sll");
            4: runInstr(OP_RTYPE, FN_SLLV, PH_SLLV, "sllv");
            5: runInstr(OP_RTYPE, FN_SRA, PH_SRA, "sra");
            6: runInstr(OP_RTYPE, FN_SRAV, PH_SRAV, "srav");
            7: runInstr(OP_RTYPE, 6'h3f, PH_FETCH, "unknown funct");
            default: runInstr(6'h3f, FN_ADD, PH_FETCH, "unknown opcode");
        endcase
    endtask

    task automatic resetMidShift();
        checkNext(expectedWord(PH_FETCH, 2'd1), "mid reset fetch 1");
        opcode = OP_RTYPE;
        funct  = FN_SRA;
        checkNext(expectedWord(PH_FETCH, 2'd2), "mid reset fetch 2");
        checkNext(expectedWord(PH_SRA, 2'd0), "mid reset shift 0");
        // held phase is now shift step 1
        rst = 1'b1;
        checkNext(expectedWord(PH_RESET, 2'd0), "mid reset clear");
        checkNext(expectedWord(PH_SP_INIT, 2'd0), "mid reset sp init");
        rst = 1'b0;
        checkNext(expectedWord(PH_FETCH, 2'd0), "mid reset fetch 0");
        finishTest("reset mid shift");
    endtask

    initial begin
        int i;
        int j;
        int tmp;
        clk         = 1'b0;
        rst         = 1'b1;
        opcode      = 6'h3f;
        funct       = 6'h3f;
        testErrors  = 0;
        testsPassed = 0;
        testsFailed = 0;
        void'($urandom(64));
        for (i = 0; i < 9; i = i + 1) begin
            order[i] = i;
        end
        for (i = 8; i > 0; i = i - 1) begin
            j        = $urandom % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end

        resetTest();
        fetchTest();
        for (i = 0; i < 9; i = i + 1) begin
            runTestById(order[i]);
        end
        resetMidShift();

        $display("tests passed: %0d, tests failed: %0d", testsPassed, testsFailed);
        if (testsFailed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
ctrlPkg.sv
instrDecoder.sv
stepSequencer.sv
controlWordGen.sv
controlUnit.sv
controlUnitTb.sv
